//--- sources.f
src/led_display_pkg.sv
src/uart_rx.sv
src/char_buffer.sv
src/hex_segment_decoder.sv
src/display_scanner.sv
src/uart_display_top.sv
tb/tb_uart_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the UART display monitor testbench with Verilator and run it.
# The exit status is the simulator's own status.
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_uart_display
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -Mdir "$OBJ" -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

"./$OBJ/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
fi
exit "$status"

//--- tb/tb_uart_display.sv
//**************************************************************************
// uart byte monitor testbench
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_uart_display import led_display_pkg::*; ();

	localparam int CLKS_PER_BIT = 16;
	localparam int SLOT_CLKS    = 8;

	logic      clk;
	logic      rst_n;
	logic      rx;
	logic      clear_btn;
	display_t  disp;

	// expected characters, left pair is the older byte
	char_set_t model;
	logic      check_en;
	int        seed;
	// written only by the compare process
	int        edges;
	int        lit_stamp [4];
	logic [15:0] seen_hex;
	logic [1:0]  digit;
	logic        lit;
	hex_char_t   cur;
	anode_t      exp_an;

	uart_display_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.SLOT_CLKS    (SLOT_CLKS)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.clear_btn (clear_btn),
		.disp      (disp)
	);

	always #10 clk = ~clk;

	// common active low pattern, built from the lit segments gfedcba
	function automatic seg_t seg_for_char(input hex_char_t ch);
		seg_t on;
		case (ch)
			4'h0: on = 7'b0111111;
			4'h1: on = 7'b0000110;
			4'h2: on = 7'b1011011;
			4'h3: on = 7'b1001111;
			4'h4: on = 7'b1100110;
			4'h5: on = 7'b1101101;
			4'h6: on = 7'b1111101;
			4'h7: on = 7'b0000111;
			4'h8: on = 7'b1111111;
			4'h9: on = 7'b1101111;
			4'hA: on = 7'b1110111;
			// lower case b
			4'hB: on = 7'b1111100;
			4'hC: on = 7'b0111001;
			// lower case d
			4'hD: on = 7'b1011110;
			4'hE: on = 7'b1111001;
			default: on = 7'b1110001;
		endcase
		return ~on;
	endfunction

	// digit n lit only in slot 4n+2
	function automatic anode_t anode_for_slot(input scan_slot_t slot);
		case (slot)
			4'd2:    return 4'b1110;
			4'd6:    return 4'b1101;
			4'd10:   return 4'b1011;
			4'd14:   return 4'b0111;
			default: return 4'b1111;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	// compare process, disp sampled before this edge updates it
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			edges     = 0;
			// no digit lit yet
			lit_stamp = '{default: -1};
			seen_hex  = '0;
		end
		else
		begin
			// pins lag the slot by one clock, reset value on the first edge
			if (edges == 0)
				exp_an = 4'hF;
			else
				exp_an = anode_for_slot(scan_slot_t'((edges - 1) / SLOT_CLKS));
			check_value("disp.an", {12'h0, exp_an}, {12'h0, disp.an});
			lit = 1'b1;
			case (disp.an)
				4'b1110: digit = 2'd0;
				4'b1101: digit = 2'd1;
				4'b1011: digit = 2'd2;
				4'b0111: digit = 2'd3;
				default: lit = 1'b0;
			endcase
			if (lit && check_en)
			begin
				cur = model[{digit, 2'b00} +: 4];
				check_value("disp.seg", {9'h0, seg_for_char(cur)}, {9'h0, disp.seg});
				lit_stamp[digit] = edges;
				seen_hex[cur]    = 1'b1;
			end
			edges++;
		end
	end

	task automatic idle_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	// 8n1 frame, lsb first, optional low stop bit
	task automatic send_byte(input byte_t b, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, b, 1'b0};
		repeat (10)
		begin
			rx    = frame[0];
			frame = frame >> 1;
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		rx = 1'b1;
	endtask

	// every digit must be lit and checked at least once
	task automatic await_full_scan();
		int start;
		int waited;
		start  = edges;
		waited = 0;
		while (!(lit_stamp[0] >= start && lit_stamp[1] >= start &&
			lit_stamp[2] >= start && lit_stamp[3] >= start) &&
			waited < 20 * SLOT_CLKS)
		begin
			@(negedge clk);
			waited++;
		end
		if (!(lit_stamp[0] >= start && lit_stamp[1] >= start &&
			lit_stamp[2] >= start && lit_stamp[3] >= start))
			abort_run("not all four digits lit within 20 slot times");
	endtask

	// checks paused while the frame is in flight
	task automatic deliver_byte(input byte_t b, input logic bad_stop);
		check_en = 1'b0;
		send_byte(b, bad_stop);
		idle_clocks(30 * CLKS_PER_BIT);
		if (!bad_stop)
			model = {model.char_an1, model.char_an0, b[7:4], b[3:0]};
		check_en = 1'b1;
		await_full_scan();
	endtask

	task automatic press_clear();
		check_en  = 1'b0;
		clear_btn = 1'b1;
		@(negedge clk);
		clear_btn = 1'b0;
		idle_clocks(4);
		model    = '0;
		check_en = 1'b1;
		await_full_scan();
	endtask

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		rx        = 1'b1;
		clear_btn = 1'b0;
		check_en  = 1'b0;
		model     = '0;
		seed      = 52;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		// dark right after reset, then zeros everywhere
		check_value("disp.an", 16'h000F, {12'h0, disp.an});
		check_en = 1'b1;
		await_full_scan();
		// first byte, left pair still zero
		deliver_byte(8'hA5, 1'b0);
		repeat (20)
			deliver_byte(byte_t'($random(seed)), 1'b0);
		// sweep so every decoder entry is shown
		for (int k = 0; k < 8; k++)
			deliver_byte(byte_t'(k * 34 + 1), 1'b0);
		check_value("hex values shown", 16'hFFFF, seen_hex);
		// bad stop bit, model untouched
		deliver_byte(8'h5A, 1'b1);
		press_clear();
		deliver_byte(8'h3C, 1'b0);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/uart_display_top.sv
//**************************************************************************
// uart byte monitor top
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module uart_display_top import led_display_pkg::*; #(
	parameter int CLKS_PER_BIT = 434,
	parameter int SLOT_CLKS    = 50000
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rx,
	input  logic     clear_btn,
	output display_t disp
);

	// receiver to buffer
	byte_t     rx_data;
	logic      rx_valid;
	// buffer to scanner
	char_set_t chars;

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx       (rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	char_buffer u_buf (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.clear_btn (clear_btn),
		.chars     (chars)
	);

	display_scanner #(
		.SLOT_CLKS (SLOT_CLKS)
	) u_scan (
		.clk   (clk),
		.rst_n (rst_n),
		.chars (chars),
		.disp  (disp)
	);

endmodule

`default_nettype wire

//--- src/display_scanner.sv
//**************************************************************************
// four digit display scanner
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module display_scanner import led_display_pkg::*; #(
	parameter int SLOT_CLKS = 50000
) (
	input  logic      clk,
	input  logic      rst_n,
	input  char_set_t chars,
	output display_t  disp
);

	localparam int PRE_W = $clog2(SLOT_CLKS);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(SLOT_CLKS - 1);

	logic [PRE_W-1:0] pre_cnt;
	scan_slot_t       slot;
	hex_char_t        cur_char;
	seg_t             cur_seg;
	anode_t           an_next;

	// prescaler, one slot every SLOT_CLKS clocks
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pre_cnt <= '0;
			slot    <= '0;
		end
		else if (pre_cnt == PRE_LAST)
		begin
			pre_cnt <= '0;
			// wraps 15 to 0 by width
			slot    <= slot + 1'b1;
		end
		else
		begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// character picked one slot before its digit group
	// two settled slots before the anode goes low
	always_comb
	begin
		case (slot)
			4'd15, 4'd0, 4'd1, 4'd2:  cur_char = chars.char_an0;
			4'd3, 4'd4, 4'd5, 4'd6:   cur_char = chars.char_an1;
			4'd7, 4'd8, 4'd9, 4'd10:  cur_char = chars.char_an2;
			4'd11, 4'd12, 4'd13, 4'd14: cur_char = chars.char_an3;
		endcase
	end

	// anode n low only in slot 4n+2, all dark otherwise
	always_comb
	begin
		for (int n = 0; n < 4; n++)
			an_next[n] = (slot != scan_slot_t'(4 * n + 2));
	end

	hex_segment_decoder u_dec (
		.ch  (cur_char),
		.seg (cur_seg)
	);

	// registered pins, one clock behind the slot
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			disp.seg <= '1;
			disp.an  <= '1;
		end
		else
		begin
			disp.seg <= cur_seg;
			disp.an  <= an_next;
		end
	end

	// never two digits lit together
	a_one_anode: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(~disp.an));

endmodule

`default_nettype wire

//--- src/hex_segment_decoder.sv
//**************************************************************************
// hex to seven segment decode
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module hex_segment_decoder import led_display_pkg::*; (
	input  hex_char_t ch,
	output seg_t      seg
);

	// active low, bit order g f e d c b a
	always_comb
	begin
		case (ch)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'hA: seg = 7'b0001000;
			// lower case b and d, so they differ from 8 and 0
			4'hB: seg = 7'b0000011;
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001;
			4'hE: seg = 7'b0000110;
			4'hF: seg = 7'b0001110;
		endcase
	end

endmodule

`default_nettype wire

//--- src/char_buffer.sv
//**************************************************************************
// two byte character history
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module char_buffer import led_display_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  byte_t     rx_data,
	input  logic      rx_valid,
	input  logic      clear_btn,
	output char_set_t chars
);

	// newest byte lands on the right two digits
	// the byte before it moves to the left two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			chars <= '0;
		end
		else if (clear_btn)
		begin
			// clear wins over a byte arriving the same clock
			chars <= '0;
		end
		else if (rx_valid)
		begin
			chars.char_an3 <= chars.char_an1;
			chars.char_an2 <= chars.char_an0;
			// high nibble on the left of the pair
			chars.char_an1 <= rx_data[7:4];
			chars.char_an0 <= rx_data[3:0];
		end
	end

	// a clear shows up as all zero one clock later
	a_clear_zero: assert property (@(posedge clk) disable iff (!rst_n)
		clear_btn |=> (chars == '0));

endmodule

`default_nettype wire

//--- src/uart_rx.sv
//**************************************************************************
// uart 8n1 receiver
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module uart_rx import led_display_pkg::*; #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  rx,
	output byte_t rx_data,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	// start bit checked at half a bit
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
	// data and stop bits sampled one full bit later
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	rx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic             rx_meta;
	logic             rx_sync;

	// two flop synchronizer, idles high like the line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// data state is package scoped, the port shares its name
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= rx_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			// strobe lasts one clock only
			rx_valid <= 1'b0;
			case (state)
				rx_idle:
				begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start:
				begin
					if (clk_cnt == HALF_BIT)
					begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// high again means a glitch
						state   <= rx_sync ? rx_idle : led_display_pkg::rx_data;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				led_display_pkg::rx_data:
				begin
					if (clk_cnt == LAST_CNT)
					begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				rx_stop:
				begin
					if (clk_cnt == LAST_CNT)
					begin
						// low stop bit drops the frame
						rx_valid <= rx_sync;
						clk_cnt  <= '0;
						state    <= rx_idle;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default:
					state <= rx_idle;
			endcase
		end
	end

	// lsb first, shifts in from the top at each mid bit
	always_ff @(posedge clk)
	begin
		if (state == led_display_pkg::rx_data && clk_cnt == LAST_CNT)
			rx_data <= {rx_sync, rx_data[7:1]};
	end

	a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- src/led_display_pkg.sv
//**************************************************************************
// serial byte monitor shared types
//**************************************************************************

`default_nettype none

package led_display_pkg;

	// one hex digit on the display
	typedef logic [3:0] hex_char_t;
	// one received uart byte
	typedef logic [7:0] byte_t;
	// scanner position, 16 slots per frame
	typedef logic [3:0] scan_slot_t;
	// active low segments, g down to a
	typedef logic [6:0] seg_t;
	// active low anodes, bit n drives digit n
	typedef logic [3:0] anode_t;

	// four characters currently shown, left to right
	typedef struct packed {
		hex_char_t char_an3;
		hex_char_t char_an2;
		hex_char_t char_an1;
		hex_char_t char_an0;
	} char_set_t;

	// pattern sent to the board pins
	typedef struct packed {
		seg_t   seg;
		anode_t an;
	} display_t;

	// receiver fsm
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

`default_nettype wire
